//--- rvPipe.f
+incdir+.
rvPipePkg.sv
controlUnit.sv
functionUnit.sv
regFile.sv
dataMemory.sv
datapath.sv
rvPipeCore.sv
tbRvPipe.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns --top-module tbRvPipe -f rvPipe.f -o simRvPipe

# $fatal gives a non-zero exit, so the log decides the result
./obj_dir/simRvPipe > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"

//--- tbRvPipe.sv
// testbench for rvPipeCore checking a random RV32I program against a reference model

`timescale 1ns/1ns

`include "rvPipe_params.svh"

module tbRvPipe;
    import rvPipePkg::*;

    localparam int NUM_INSTR = 400;
    localparam int RESET_CYCLES = 10;
    // bubbles budgeted at twice the expected one-in-eight rate
    localparam int TIMEOUT_CYCLES = NUM_INSTR + NUM_INSTR / 4 + RESET_CYCLES + 50;

    typedef struct packed {
        logic [31:0] due;
        wbPort_t     rec;
    } expEntry_t;

    logic             clk = 1'b0;
    logic             rstN;
    instrWord_u       instr;
    logic             instrValid;
    wbPort_t          wbOut;

    logic [`XLEN-1:0] modelRegs [`REG_COUNT];
    logic [7:0]       modelBytes [`DMEM_WORDS*4];
    logic [15:0]      lfsrState = 16'd54351;
    logic [31:0]      cycleCount = '0;
    expEntry_t        expQ [$];

    rvPipeCore uut (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .wb         (wbOut)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits = {bits[30:0], lfsrState[0]};
        end
        return bits;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end else begin
                    return a >> b[4:0];
                end
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] loadRef(input logic [2:0] f3, input logic [8:0] addr);
        logic [31:0] word;
        word = {modelBytes[addr + 9'd3], modelBytes[addr + 9'd2],
                modelBytes[addr + 9'd1], modelBytes[addr]};
        case (f3)
            3'b000: return {{24{word[7]}}, word[7:0]};
            3'b001: return {{16{word[15]}}, word[15:0]};
            3'b100: return {24'b0, word[7:0]};
            3'b101: return {16'b0, word[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic void storeRef(input logic [2:0] f3, input logic [8:0] addr,
                                     input logic [31:0] data);
        modelBytes[addr] = data[7:0];
        if (f3 != 3'b000) modelBytes[addr + 9'd1] = data[15:8];
        if (f3 == 3'b010) modelBytes[addr + 9'd2] = data[23:16];
        if (f3 == 3'b010) modelBytes[addr + 9'd3] = data[31:24];
    endfunction

    // executes one instruction on the model state in program order
    function automatic wbPort_t refExecute(input logic [31:0] w, input logic [31:0] pc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] addr;
        logic [31:0] result;
        logic        writes;
        wbPort_t     rec;
        a = modelRegs[w[19:15]];
        b = modelRegs[w[24:20]];
        immI = {{20{w[31]}}, w[31:20]};
        immS = {{20{w[31]}}, w[31:25], w[11:7]};
        writes = 1'b1;
        result = '0;
        case (w[6:0])
            7'b0110011: result = aluRef(w[14:12], w[30], a, b);
            7'b0010011: result = aluRef(w[14:12], (w[14:12] == 3'b101) && w[30], a, immI);
            7'b0110111: result = {w[31:12], 12'b0};
            7'b0010111: result = pc + {w[31:12], 12'b0};
            7'b0000011: begin
                addr = a + immI;
                result = loadRef(w[14:12], addr[8:0]);
            end
            7'b0100011: begin
                addr = a + immS;
                storeRef(w[14:12], addr[8:0], b);
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        // x0 stays zero for later reads but the write is still reported
        if (writes && w[11:7] != 5'd0) modelRegs[w[11:7]] = result;
        rec.valid = writes;
        rec.rd = w[11:7];
        rec.data = result;
        return rec;
    endfunction

    function automatic logic [31:0] randomInstr();
        logic [2:0]  cls;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [6:0]  f7;
        logic [11:0] imm;
        cls = 3'(takeBits(3));
        f3  = 3'(takeBits(3));
        rd  = 5'(takeBits(3));
        rs1 = 5'(takeBits(3));
        rs2 = 5'(takeBits(3));
        f7  = (takeBits(1) != 0) ? 7'b0100000 : 7'b0000000;
        case (cls)
            3'd0, 3'd1: begin
                // only add/sub and srl/sra have an alternate encoding
                if (f3 != 3'b000 && f3 != 3'b101) f7 = 7'b0;
                return {f7, rs2, rs1, f3, rd, 7'b0110011};
            end
            3'd2, 3'd3: begin
                imm = 12'(takeBits(12));
                if (f3 == 3'b001 || f3 == 3'b101) imm = {(f3 == 3'b101) ? f7 : 7'b0, imm[4:0]};
                return {imm, rs1, f3, rd, 7'b0010011};
            end
            3'd4, 3'd5: begin
                // x0 base within the low 64 bytes and aligned to the access size
                if (cls == 3'd5) f3 = {1'b0, f3[1:0]};
                if (f3[1:0] == 2'b11) f3[1:0] = 2'b10;
                if (f3 == 3'b110) f3 = 3'b100;
                imm = {6'b0, 4'(takeBits(4)), 2'b00};
                if (f3[1:0] == 2'b00) imm[1:0] = 2'(takeBits(2));
                if (f3[1:0] == 2'b01) imm[1] = takeBits(1) != 0;
                if (cls == 3'd4) return {imm, 5'd0, f3, rd, 7'b0000011};
                return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
            end
            3'd6: return {20'(takeBits(20)), rd, 7'b0110111};
            default: return {20'(takeBits(20)), rd, 7'b0010111};
        endcase
    endfunction

    // wb is sampled at the falling edge once per cycle
    always @(negedge clk) begin
        expEntry_t entry;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation timed out");
        end else begin
            if (expQ.size() != 0 && expQ[0].due == cycleCount) begin
                entry = expQ.pop_front();
                checkValue("wb.valid", {31'b0, wbOut.valid}, 32'd1);
                checkValue("wb.rd", {27'b0, wbOut.rd}, {27'b0, entry.rec.rd});
                checkValue("wb.data", wbOut.data, entry.rec.data);
            end else begin
                checkValue("idle wb.valid", {31'b0, wbOut.valid}, 32'd0);
            end
            cycleCount = cycleCount + 32'd1;
        end
    end

    initial begin
        logic [31:0] word;
        logic [31:0] modelPc;
        int          issued;
        wbPort_t     rec;
        expEntry_t   entry;
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        modelPc = '0;
        issued = 0;
        for (int i = 0; i < `REG_COUNT; i++) modelRegs[i] = '0;
        for (int i = 0; i < `DMEM_WORDS * 4; i++) modelBytes[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        while (issued < NUM_INSTR) begin
            @(posedge clk);
            if (takeBits(3) == 0) begin
                instrValid <= 1'b0;
            end else begin
                word = randomInstr();
                instr <= word;
                instrValid <= 1'b1;
                rec = refExecute(word, modelPc);
                modelPc = modelPc + 32'd4;
                // DUT samples at the next edge and wb shows it four negedges on
                entry.due = cycleCount + 32'd4;
                entry.rec = rec;
                if (rec.valid) expQ.push_back(entry);
                issued++;
            end
        end
        @(posedge clk);
        instrValid <= 1'b0;
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        // drained pipeline must stay quiet
        repeat (4) @(posedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- rvPipeCore.sv
// rvPipe top level, wires decode, datapath, ALU, register file and data RAM

`timescale 1ns/1ns

`include "rvPipe_params.svh"

module rvPipeCore (
    input  logic                  clk,
    input  logic                  rstN,
    input  rvPipePkg::instrWord_u instr,
    input  logic                  instrValid,
    output rvPipePkg::wbPort_t    wb
);
    import rvPipePkg::*;

    idStage_t         idStage;
    memReq_t          memReq;
    logic [4:0]       rfAddr0;
    logic [4:0]       rfAddr1;
    logic [`XLEN-1:0] rfData0;
    logic [`XLEN-1:0] rfData1;
    logic [`XLEN-1:0] aluA;
    logic [`XLEN-1:0] aluB;
    logic [`XLEN-1:0] aluS;
    logic [3:0]       aluFs;
    logic [`XLEN-1:0] memData;

    controlUnit ctrlInst (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .idOut      (idStage)
    );

    datapath dpInst (
        .clk     (clk),
        .rstN    (rstN),
        .idIn    (idStage),
        .rfAddr0 (rfAddr0),
        .rfAddr1 (rfAddr1),
        .rfData0 (rfData0),
        .rfData1 (rfData1),
        .aluA    (aluA),
        .aluB    (aluB),
        .aluFs   (aluFs),
        .aluS    (aluS),
        .mem     (memReq),
        .memData (memData),
        .wb      (wb)
    );

    functionUnit fuInst (
        .a  (aluA),
        .b  (aluB),
        .fs (aluFs),
        .s  (aluS)
    );

    // retire port doubles as the write port
    regFile rfInst (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddr0 (rfAddr0),
        .rdAddr1 (rfAddr1),
        .rdData0 (rfData0),
        .rdData1 (rfData1),
        .wr      (wb)
    );

    dataMemory dmInst (
        .clk    (clk),
        .req    (memReq),
        .rdData (memData)
    );

endmodule

//--- datapath.sv
// EX, MEM and WB stages with forwarding, memory alignment and writeback select

`timescale 1ns/1ns

`include "rvPipe_params.svh"

module datapath (
    input  logic                clk,
    input  logic                rstN,
    input  rvPipePkg::idStage_t idIn,
    output logic [4:0]          rfAddr0,
    output logic [4:0]          rfAddr1,
    input  logic [`XLEN-1:0]    rfData0,
    input  logic [`XLEN-1:0]    rfData1,
    output logic [`XLEN-1:0]    aluA,
    output logic [`XLEN-1:0]    aluB,
    output logic [3:0]          aluFs,
    input  logic [`XLEN-1:0]    aluS,
    output rvPipePkg::memReq_t  mem,
    input  logic [`XLEN-1:0]    memData,
    output rvPipePkg::wbPort_t  wb
);
    import rvPipePkg::*;

    ctrlWord_t        exCtrl;
    ctrlWord_t        memCtrl;
    ctrlWord_t        wbCtrl;
    logic [`XLEN-1:0] exImm;
    logic [`XLEN-1:0] exPc;
    logic [`XLEN-1:0] exRs1;
    logic [`XLEN-1:0] exRs2;
    logic [`XLEN-1:0] memImm;
    logic [`XLEN-1:0] memAlu;
    logic [`XLEN-1:0] memRs2;
    logic [`XLEN-1:0] wbData;
    logic [`XLEN-1:0] fwdRs1;
    logic [`XLEN-1:0] fwdRs2;
    logic [`XLEN-1:0] memWbData;
    logic [`XLEN-1:0] loadShift;
    logic [`XLEN-1:0] loadData;
    logic [1:0]       byteOff;
    logic             memFwd;
    logic             wbFwd;

    // every class but store and bubble produces a register result
    function automatic logic writesRd(input instType_e t);
        return (t != STORE) && (t != NOP);
    endfunction

    // register reads happen in ID
    assign rfAddr0 = idIn.ctrl.rs1;
    assign rfAddr1 = idIn.ctrl.rs2;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exCtrl  <= ctrlNop;
            memCtrl <= ctrlNop;
            wbCtrl  <= ctrlNop;
        end else begin
            exCtrl  <= idIn.ctrl;
            memCtrl <= exCtrl;
            wbCtrl  <= memCtrl;
        end
    end

    always_ff @(posedge clk) begin
        exImm  <= idIn.imm;
        exPc   <= idIn.pc;
        exRs1  <= rfData0;
        exRs2  <= rfData1;
        memImm <= exImm;
        memAlu <= aluS;
        memRs2 <= fwdRs2;
        wbData <= memWbData;
    end

    // forwarding, MEM result first, then WB, then the ID read
    assign memFwd = writesRd(memCtrl.instType) && (memCtrl.rd != 5'd0);
    assign wbFwd  = writesRd(wbCtrl.instType) && (wbCtrl.rd != 5'd0);

    assign fwdRs1 = (memFwd && memCtrl.rd == exCtrl.rs1) ? memWbData :
                    (wbFwd && wbCtrl.rd == exCtrl.rs1)   ? wbData : exRs1;
    assign fwdRs2 = (memFwd && memCtrl.rd == exCtrl.rs2) ? memWbData :
                    (wbFwd && wbCtrl.rd == exCtrl.rs2)   ? wbData : exRs2;

    assign aluA = (exCtrl.instType == AUIPC) ? exPc : fwdRs1;
    assign aluB = (exCtrl.instType == REG) ? fwdRs2 : exImm;

    always_comb begin
        case (exCtrl.instType)
            REG: aluFs = {exCtrl.fun3, exCtrl.fun7};
            // only srai keeps the funct7 bit for immediates
            IMM: aluFs = {exCtrl.fun3, (exCtrl.fun3 == 3'b101) & exCtrl.fun7};
            default: aluFs = 4'b0000;
        endcase
    end

    // MEM stage, store side
    assign byteOff = memAlu[1:0];

    always_comb begin
        mem.we       = (memCtrl.instType == STORE);
        mem.wordAddr = memAlu[`DMEM_AW+1:2];
        mem.wrData   = memRs2 << {byteOff, 3'b000};
        case (memCtrl.fun3[1:0])
            2'b00:   mem.byteEn = 4'b0001 << byteOff;
            2'b01:   mem.byteEn = byteOff[1] ? 4'b1100 : 4'b0011;
            default: mem.byteEn = 4'b1111;
        endcase
    end

    // MEM stage, load side
    assign loadShift = memData >> {byteOff, 3'b000};

    always_comb begin
        case (memCtrl.fun3)
            3'b000:  loadData = {{24{loadShift[7]}}, loadShift[7:0]};
            3'b001:  loadData = {{16{loadShift[15]}}, loadShift[15:0]};
            3'b100:  loadData = {24'b0, loadShift[7:0]};
            3'b101:  loadData = {16'b0, loadShift[15:0]};
            default: loadData = memData;
        endcase
    end

    always_comb begin
        case (memCtrl.instType)
            LOAD:    memWbData = loadData;
            LUI:     memWbData = memImm;
            default: memWbData = memAlu;
        endcase
    end

    // retire port, also the register file write
    assign wb = '{valid: writesRd(wbCtrl.instType), rd: wbCtrl.rd, data: wbData};

endmodule

//--- dataMemory.sv
// word-organized data RAM, byte-lane writes and combinational read

`timescale 1ns/1ns

`include "rvPipe_params.svh"

module dataMemory (
    input  logic              clk,
    input  rvPipePkg::memReq_t req,
    output logic [`XLEN-1:0]  rdData
);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];

    // power-up contents are zero
    initial begin
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (req.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (req.byteEn[lane]) begin
                    mem[req.wordAddr][lane*8 +: 8] <= req.wrData[lane*8 +: 8];
                end
            end
        end
    end

    // read in the same cycle so loads forward from MEM
    assign rdData = mem[req.wordAddr];

endmodule

//--- regFile.sv
// two-read one-write register file, x0 fixed at zero, write-through reads

`timescale 1ns/1ns

`include "rvPipe_params.svh"

module regFile (
    input  logic              clk,
    input  logic              rstN,
    input  logic [4:0]        rdAddr0,
    input  logic [4:0]        rdAddr1,
    output logic [`XLEN-1:0]  rdData0,
    output logic [`XLEN-1:0]  rdData1,
    input  rvPipePkg::wbPort_t wr
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             wrEn;

    // x0 writes are dropped here, the retire port still shows them
    assign wrEn = wr.valid && (wr.rd != 5'd0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // same-cycle write wins over the stored value
    assign rdData0 = (wrEn && wr.rd == rdAddr0) ? wr.data : regs[rdAddr0];
    assign rdData1 = (wrEn && wr.rd == rdAddr1) ? wr.data : regs[rdAddr1];

endmodule

//--- functionUnit.sv
// combinational integer ALU, select is funct3 with the funct7 bit appended

`timescale 1ns/1ns

`include "rvPipe_params.svh"

module functionUnit (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  logic [3:0]       fs,
    output logic [`XLEN-1:0] s
);

    always_comb begin
        case (fs)
            4'b0000: s = a + b;
            4'b0001: s = a - b;
            4'b0010: s = a << b[4:0];
            4'b0100: s = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            4'b0110: s = {{(`XLEN-1){1'b0}}, a < b};
            4'b1000: s = a ^ b;
            4'b1010: s = a >> b[4:0];
            // arithmetic shift keeps the sign
            4'b1011: s = $signed(a) >>> b[4:0];
            4'b1100: s = a | b;
            4'b1110: s = a & b;
            // address and auipc sums land here too
            default: s = a + b;
        endcase
    end

endmodule

//--- controlUnit.sv
// instruction decode stage: opcode classing, immediate build and pc counter

`timescale 1ns/1ns

`include "rvPipe_params.svh"

module controlUnit (
    input  logic                 clk,
    input  logic                 rstN,
    input  rvPipePkg::instrWord_u instr,
    input  logic                 instrValid,
    output rvPipePkg::idStage_t  idOut
);
    import rvPipePkg::*;

    ctrlWord_t        decCtrl;
    logic [`XLEN-1:0] decImm;
    ctrlWord_t        ctrlQ;
    logic [`XLEN-1:0] immQ;
    logic [`XLEN-1:0] pcQ;
    logic [`XLEN-1:0] pcCount;

    always_comb begin
        decCtrl.fun3 = instr.ri.funct3;
        // bit 30 picks sub and sra
        decCtrl.fun7 = instr.ri.funct7[5];
        decCtrl.rd   = instr.ri.rd;
        decCtrl.rs1  = instr.ri.rs1;
        decCtrl.rs2  = instr.ri.rs2;
        // I-type immediate unless the class says otherwise
        decImm = {{20{instr.ri.funct7[6]}}, instr.ri.funct7, instr.ri.rs2};
        case (instr.ri.opcode)
            7'b0000011: decCtrl.instType = LOAD;
            7'b0010011: decCtrl.instType = IMM;
            7'b0110011: decCtrl.instType = REG;
            7'b0100011: begin
                decCtrl.instType = STORE;
                decImm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            end
            7'b0110111, 7'b0010111: begin
                decCtrl.instType = (instr.ri.opcode[5]) ? LUI : AUIPC;
                decImm = {instr.ri.funct7, instr.ri.rs2, instr.ri.rs1, instr.ri.funct3, 12'b0};
            end
            // unsupported opcodes travel as bubbles
            default: decCtrl.instType = NOP;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlQ   <= ctrlNop;
            pcCount <= '0;
        end else begin
            ctrlQ <= instrValid ? decCtrl : ctrlNop;
            // pc moves only on accepted words
            if (instrValid) begin
                pcCount <= pcCount + `XLEN'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        immQ <= decImm;
        pcQ  <= pcCount;
    end

    assign idOut = '{ctrl: ctrlQ, imm: immQ, pc: pcQ};

endmodule

//--- rvPipePkg.sv
// rvPipe shared types for instruction views, the stage control word and port structs

`include "rvPipe_params.svh"

package rvPipePkg;

    // instruction classes with NOP marking a bubble
    typedef enum logic [3:0] {
        LOAD  = 4'd0,
        IMM   = 4'd1,
        STORE = 4'd2,
        REG   = 4'd3,
        LUI   = 4'd4,
        AUIPC = 4'd5,
        NOP   = 4'd15
    } instType_e;

    // R and I formats with the U immediate in the upper 20 bits
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } riView_t;

    // S format with the immediate split around the register fields
    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sView_t;

    typedef union packed {
        riView_t ri;
        sView_t  s;
    } instrWord_u;

    // stage control word with rs2 on top and the type at the bottom
    typedef struct packed {
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [4:0] rd;
        logic       fun7;
        logic [2:0] fun3;
        instType_e  instType;
    } ctrlWord_t;

    localparam ctrlWord_t ctrlNop = '{instType: NOP, default: '0};

    typedef struct packed {
        ctrlWord_t         ctrl;
        logic [`XLEN-1:0]  imm;
        logic [`XLEN-1:0]  pc;
    } idStage_t;

    typedef struct packed {
        logic                we;
        logic [`DMEM_AW-1:0] wordAddr;
        logic [`XLEN-1:0]    wrData;
        logic [3:0]          byteEn;
    } memReq_t;

    typedef struct packed {
        logic             valid;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
    } wbPort_t;

endpackage

//--- rvPipe_params.svh
// rvPipe sizing constants shared by the package and the RTL modules

`ifndef RVPIPE_PARAMS_SVH
`define RVPIPE_PARAMS_SVH

// integer data path width
`define XLEN 32

// data memory size in 32-bit words
`define DMEM_WORDS 128

// word address width, log2 of the word count
`define DMEM_AW 7

// architectural registers, x0 included
`define REG_COUNT 32

`endif
